/* src/CsrPkg.sv */
`default_nettype none

package CsrPkg;

    // ------------------------------------------------------------------------
    // Data types
    // ------------------------------------------------------------------------

    typedef logic [31:0] Data;      // CSR value
    typedef logic [11:0] CsrAddr;   // CSR number
    typedef logic [32:0] HpmCount;  // Counter with carry bit

    typedef enum logic [1:0] {
        CsrOp_NOP,                  // Read only
        CsrOp_WRITE,
        CsrOp_SET,
        CsrOp_CLEAR
    } CsrOp;

    typedef enum logic [1:0] {
        RunMode_User    = 2'b00,
        RunMode_Machine = 2'b11
    } RunMode;

    typedef enum logic [3:0] {
        HpmEvent_None       = 4'h0,
        HpmEvent_ICacheHit  = 4'h1,
        HpmEvent_ICacheMiss = 4'h2,
        HpmEvent_DCacheHit  = 4'h3,
        HpmEvent_DCacheMiss = 4'h4,
        HpmEvent_MemRead    = 4'h5,
        HpmEvent_MemWrite   = 4'h6
    } HpmEvent;

    localparam int MaxHpmCounters = 7;  // mhpmcounter3 up to mhpmcounter9

    // ------------------------------------------------------------------------
    // Identity and ISA
    // ------------------------------------------------------------------------

    // RV32IM, MXL = 1
    localparam Data MISA      = (Data'(1) << 30) | (Data'(1) << 12) | (Data'(1) << 8);
    localparam Data MVENDORID = 32'h0000_0000;
    localparam Data MARCHID   = 32'h0000_0000;
    localparam Data MIMPID    = 32'h0000_0000;
    localparam Data MHARTID   = 32'h0000_0000;

    localparam Data MSTATUS_MASK = 32'h0002_0008;  // MPRV and MIE
    localparam Data MIX_MASK     = 32'h0000_0888;  // External, timer and software bits

    // ------------------------------------------------------------------------
    // CSR addresses
    // ------------------------------------------------------------------------

    localparam CsrAddr CSR_MVENDORID     = 12'hF11;
    localparam CsrAddr CSR_MARCHID       = 12'hF12;
    localparam CsrAddr CSR_MIMPID        = 12'hF13;
    localparam CsrAddr CSR_MHARTID       = 12'hF14;
    localparam CsrAddr CSR_MSTATUS       = 12'h300;
    localparam CsrAddr CSR_MISA          = 12'h301;
    localparam CsrAddr CSR_MIE           = 12'h304;
    localparam CsrAddr CSR_MTVEC         = 12'h305;
    localparam CsrAddr CSR_MCOUNTINHIBIT = 12'h320;
    localparam CsrAddr CSR_MHPMEVENT3    = 12'h323;  // Selectors follow at +1
    localparam CsrAddr CSR_MSCRATCH      = 12'h340;
    localparam CsrAddr CSR_MEPC          = 12'h341;
    localparam CsrAddr CSR_MCAUSE        = 12'h342;
    localparam CsrAddr CSR_MIP           = 12'h344;
    localparam CsrAddr CSR_MCYCLE        = 12'hB00;
    localparam CsrAddr CSR_MINSTRET      = 12'hB02;
    localparam CsrAddr CSR_MHPMCOUNTER3  = 12'hB03;  // Counters follow at +1
    localparam CsrAddr CSR_MCYCLEH       = 12'hB80;
    localparam CsrAddr CSR_MINSTRETH     = 12'hB82;
    localparam CsrAddr CSR_MHPMCOUNTER3H = 12'hB83;

endpackage

`default_nettype wire

/* src/CsrRegisters.sv */
`timescale 1ns/10ps
`default_nettype none

module CsrRegisters
    import CsrPkg::*;
(
    input  logic   i_clock,
    input  logic   i_reset,

    input  CsrOp   i_op,         // Operation from the core
    input  CsrAddr i_csr,        // CSR number
    input  Data    i_data,       // Operand
    input  Data    i_bankData,   // Read data of the counter bank
    input  logic   i_bankHit,    // Counter bank owns the address

    output Data    o_data,       // Read data, zero when illegal
    output logic   o_illegal,
    output logic   o_bankWrite,  // Legal write into the counter bank
    output Data    o_writeData); // Value after the op is applied


    RunMode mode;                // Current privilege

    Data    mstatus;
    Data    mtvec;
    Data    mie;
    Data    mip;
    Data    mscratch;
    Data    mepc;
    Data    mcause;

    Data    ownData;             // Read data of local CSRs
    logic   ownHit;              // Local CSR decoded
    Data    readValue;           // Merged read value
    logic   badMode;
    logic   badAddr;
    logic   badWrite;            // Write to a read-only CSR
    logic   illegal;
    logic   doWrite;             // Legal modifying op


    // ------------------------------------------------------------------------
    // Read decode and legality
    // ------------------------------------------------------------------------

    always_comb begin
        ownHit  = 1'b1;
        ownData = '0;
        case (i_csr)
            CSR_MVENDORID : ownData = MVENDORID;
            CSR_MARCHID   : ownData = MARCHID;
            CSR_MIMPID    : ownData = MIMPID;
            CSR_MHARTID   : ownData = MHARTID;
            CSR_MISA      : ownData = MISA;
            CSR_MSTATUS   : ownData = mstatus;
            CSR_MTVEC     : ownData = mtvec;
            CSR_MIE       : ownData = mie;
            CSR_MIP       : ownData = mip;
            CSR_MSCRATCH  : ownData = mscratch;
            CSR_MEPC      : ownData = mepc;
            CSR_MCAUSE    : ownData = mcause;
            default       : ownHit  = 1'b0;
        endcase
    end

    assign badMode  = i_csr[9:8] != mode;
    assign badAddr  = badMode | ~(ownHit | i_bankHit);
    assign badWrite = (i_op != CsrOp_NOP) & (&i_csr[11:10]);
    assign illegal  = badAddr | badWrite;

    assign readValue = badAddr ? '0 : (ownHit ? ownData : i_bankData);
    assign o_data    = readValue;
    assign o_illegal = (i_op != CsrOp_NOP) & illegal;

    // ------------------------------------------------------------------------
    // Write value
    // ------------------------------------------------------------------------

    always_comb begin
        case (i_op)
            CsrOp_SET   : o_writeData = readValue | i_data;
            CsrOp_CLEAR : o_writeData = readValue & ~i_data;
            default     : o_writeData = i_data;
        endcase
    end

    assign doWrite     = (i_op != CsrOp_NOP) & ~illegal;
    assign o_bankWrite = doWrite & i_bankHit;

    // ------------------------------------------------------------------------
    // Machine status and trap registers
    // ------------------------------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            mode     <= RunMode_Machine;
            mstatus  <= '0;
            mtvec    <= '0;
            mie      <= '0;
            mip      <= '0;
            mscratch <= '0;
            mepc     <= '0;  // No trap entry here
            mcause   <= '0;
        end
        else if (doWrite & ownHit) begin
            case (i_csr)
                CSR_MSTATUS  : mstatus  <= o_writeData & MSTATUS_MASK;
                CSR_MTVEC    : mtvec    <= o_writeData;
                CSR_MIE      : mie      <= o_writeData & MIX_MASK;
                CSR_MIP      : mip      <= o_writeData & MIX_MASK;
                CSR_MSCRATCH : mscratch <= o_writeData;
                CSR_MCAUSE   : mcause   <= o_writeData;
                default      : ;
            endcase
        end
    end

    // Core must always present a defined operation
    assert property (@(posedge i_clock) disable iff (i_reset) !$isunknown(i_op));

    // Without trap return the hart never leaves machine mode
    assert property (@(posedge i_clock) disable iff (i_reset)
        $stable(mode) && mode == RunMode_Machine);

endmodule

`default_nettype wire

/* src/HpmCounterBank.sv */
`timescale 1ns/10ps
`default_nettype none

module HpmCounterBank
    import CsrPkg::*;
#(
    parameter int NumHpmCounters = 2)
(
    input  logic   i_clock,
    input  logic   i_reset,

    input  logic   i_write,        // Qualified write strobe
    input  CsrAddr i_csr,
    input  Data    i_writeData,

    input  logic   i_evInstRet,
    input  logic   i_evICacheHit,
    input  logic   i_evICacheMis,
    input  logic   i_evDCacheHit,
    input  logic   i_evDCacheMis,
    input  logic   i_evMemRead,
    input  logic   i_evMemWrite,

    output Data    o_readData,
    output logic   o_hit);


    // Slot 0 mcycle, slot 1 unused (time), slot 2 minstret, then mhpmcounters
    localparam int NumSlots = 3 + NumHpmCounters;
    localparam logic [NumSlots-1:0] InhibitMask = ~NumSlots'(2);

    HpmCount               counter [NumSlots];
    logic [3:0]            evSel [3:NumSlots-1];  // Raw event codes
    logic [NumSlots-1:0]   inhibit;

    logic [NumSlots-1:0]   trigger;               // Event seen this cycle
    logic [NumSlots-1:0]   cntWrite;
    logic [NumSlots-1:0]   evWrite;
    logic                  inhWrite;


    // ------------------------------------------------------------------------
    // Event selection
    // ------------------------------------------------------------------------

    always_comb begin
        trigger    = '0;
        trigger[0] = 1'b1;
        trigger[2] = i_evInstRet;
        for (int i = 3; i < NumSlots; i++) begin
            case (HpmEvent'(evSel[i]))
                HpmEvent_ICacheHit  : trigger[i] = i_evICacheHit;
                HpmEvent_ICacheMiss : trigger[i] = i_evICacheMis;
                HpmEvent_DCacheHit  : trigger[i] = i_evDCacheHit;
                HpmEvent_DCacheMiss : trigger[i] = i_evDCacheMis;
                HpmEvent_MemRead    : trigger[i] = i_evMemRead;
                HpmEvent_MemWrite   : trigger[i] = i_evMemWrite;
                default             : trigger[i] = 1'b0;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------------------

    always_comb begin
        o_hit      = 1'b0;
        o_readData = '0;
        cntWrite   = '0;
        evWrite    = '0;
        inhWrite   = 1'b0;
        if (i_csr == CSR_MCOUNTINHIBIT) begin
            o_hit      = 1'b1;
            o_readData = Data'(inhibit);
            inhWrite   = i_write;
        end
        for (int i = 0; i < NumSlots; i++) begin
            if (i != 1 && i_csr == CSR_MCYCLE + CsrAddr'(i)) begin
                o_hit       = 1'b1;
                o_readData  = counter[i][31:0];
                cntWrite[i] = i_write;
            end
            if (i != 1 && i_csr == CSR_MCYCLEH + CsrAddr'(i)) begin
                o_hit      = 1'b1;  // H word is read only in effect
                o_readData = Data'(counter[i][32]);
            end
            if (i >= 3 && i_csr == CSR_MHPMEVENT3 + CsrAddr'(i - 3)) begin
                o_hit      = 1'b1;
                o_readData = Data'(evSel[i]);
                evWrite[i] = i_write;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Counters, selectors and inhibit
    // ------------------------------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            inhibit <= InhibitMask;
            for (int i = 0; i < NumSlots; i++)
                counter[i] <= '0;
            for (int i = 3; i < NumSlots; i++)
                evSel[i] <= '0;
        end
        else begin
            for (int i = 0; i < NumSlots; i++) begin
                if (cntWrite[i])
                    counter[i] <= {1'b0, i_writeData};  // Count of this cycle lost
                else if (trigger[i] & ~inhibit[i])
                    counter[i] <= counter[i] + 1'b1;
            end
            for (int i = 3; i < NumSlots; i++) begin
                if (evWrite[i])
                    evSel[i] <= i_writeData[3:0];
            end
            if (inhWrite)
                inhibit <= i_writeData[NumSlots-1:0] & InhibitMask;
        end
    end

    // A single CSR access may load no more than one counter
    assert property (@(posedge i_clock) disable iff (i_reset) $onehot0(cntWrite));

endmodule

`default_nettype wire

/* src/CsrUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module CsrUnit
    import CsrPkg::*;
#(
    parameter int NumHpmCounters = 2)  // 1 to MaxHpmCounters
(
    input  logic   i_clock,
    input  logic   i_reset,

    input  logic   i_evInstRet,        // Instruction retired
    input  logic   i_evICacheHit,
    input  logic   i_evICacheMis,
    input  logic   i_evDCacheHit,
    input  logic   i_evDCacheMis,
    input  logic   i_evMemRead,
    input  logic   i_evMemWrite,

    input  CsrOp   i_op,
    input  CsrAddr i_csr,
    input  Data    i_data,
    output Data    o_data,
    output logic   o_illegal);


    Data  bankData;
    logic bankHit;
    logic bankWrite;
    Data  writeData;

    CsrRegisters regs_i (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_op        (i_op),
        .i_csr       (i_csr),
        .i_data      (i_data),
        .i_bankData  (bankData),
        .i_bankHit   (bankHit),
        .o_data      (o_data),
        .o_illegal   (o_illegal),
        .o_bankWrite (bankWrite),
        .o_writeData (writeData));

    HpmCounterBank #(
        .NumHpmCounters (NumHpmCounters))
    bank_i (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_write       (bankWrite),
        .i_csr         (i_csr),
        .i_writeData   (writeData),
        .i_evInstRet   (i_evInstRet),
        .i_evICacheHit (i_evICacheHit),
        .i_evICacheMis (i_evICacheMis),
        .i_evDCacheHit (i_evDCacheHit),
        .i_evDCacheMis (i_evDCacheMis),
        .i_evMemRead   (i_evMemRead),
        .i_evMemWrite  (i_evMemWrite),
        .o_readData    (bankData),
        .o_hit         (bankHit));

endmodule

`default_nettype wire

/* include/CsrRefModel.svh */
`ifndef CSR_REF_MODEL_SVH
`define CSR_REF_MODEL_SVH

// ----------------------------------------------------------------------------
// Expected CSR state, one slot per counter index as in the counter bank
// ----------------------------------------------------------------------------

Data                       refMstatus;
Data                       refMtvec;
Data                       refMie;
Data                       refMscratch;
HpmCount                   refCount [MaxHpmCounters + 3];
HpmEvent                   refEvent [MaxHpmCounters + 3];
logic [MaxHpmCounters+2:0] refInhibit;   // Bit 1 never counts

function automatic Data refWriteValue(CsrOp op, Data oldValue, Data value);
    case (op)
        CsrOp_SET   : return oldValue | value;
        CsrOp_CLEAR : return oldValue & ~value;
        default     : return value;
    endcase
endfunction

// Bits kept by a write
function automatic Data refMask(CsrAddr csr);
    case (csr)
        CSR_MSTATUS : return MSTATUS_MASK;
        CSR_MIE     : return MIX_MASK;
        default     : return 32'hFFFF_FFFF;
    endcase
endfunction

function automatic void refReset();
    refMstatus  = '0;
    refMtvec    = '0;
    refMie      = '0;
    refMscratch = '0;
    refInhibit  = '1;
    for (int i = 0; i < MaxHpmCounters + 3; i++) begin
        refCount[i] = '0;
        refEvent[i] = HpmEvent_None;
    end
endfunction

// Expected mcountinhibit read value
function automatic Data refInhibitRead(int numCounters);
    Data mask;
    mask = (Data'(1) << (numCounters + 3)) - 1;
    return Data'(refInhibit) & mask & ~Data'(2);
endfunction

// One clock of counting, pulses ordered as the HpmEvent codes 1 to 6
function automatic void refTick(logic instRet, logic [6:1] pulses);
    logic hit;
    for (int i = 0; i < MaxHpmCounters + 3; i++) begin
        case (i)
            0       : hit = 1'b1;
            1       : hit = 1'b0;
            2       : hit = instRet;
            default : hit = (refEvent[i] inside {[1:6]}) ? pulses[refEvent[i]] : 1'b0;
        endcase
        if (hit && !refInhibit[i])
            refCount[i] = refCount[i] + 1'b1;
    end
endfunction

`endif

/* testbench/CsrUnitTb.sv */
`timescale 1ns/10ps
`default_nettype none

module CsrUnitTb
    import CsrPkg::*;
();

    localparam int NumCounters = 2;
    localparam int Period      = 20;
    localparam int RandomOps   = 60;              // Modify plus read back each
    localparam int CountCycles = 40;
    localparam int Gap         = 17;              // mcycle read distance
    localparam int EventCycles = 50;              // Per phase of the event test
    localparam int TestCycles  = 40 + 2 * RandomOps + 10 + CountCycles + Gap + 2 * EventCycles + 12;
    localparam int Margin      = 100;

    logic   clock;
    logic   reset;
    logic   evInstRet;
    logic   evICacheHit;
    logic   evICacheMis;
    logic   evDCacheHit;
    logic   evDCacheMis;
    logic   evMemRead;
    logic   evMemWrite;
    CsrOp   op;
    CsrAddr csr;
    Data    dataIn;
    Data    dataOut;
    logic   illegal;

    int     seed = 48298;
    int     dataErrors;
    int     illegalErrors;
    Data    lastRead;                             // Value seen by the last access

    `include "CsrRefModel.svh"

    CsrUnit #(
        .NumHpmCounters (NumCounters))
    dut_i (
        .i_clock       (clock),
        .i_reset       (reset),
        .i_evInstRet   (evInstRet),
        .i_evICacheHit (evICacheHit),
        .i_evICacheMis (evICacheMis),
        .i_evDCacheHit (evDCacheHit),
        .i_evDCacheMis (evDCacheMis),
        .i_evMemRead   (evMemRead),
        .i_evMemWrite  (evMemWrite),
        .i_op          (op),
        .i_csr         (csr),
        .i_data        (dataIn),
        .o_data        (dataOut),
        .o_illegal     (illegal));

    initial begin
        clock = 1'b0;
        forever #(Period / 2) clock = ~clock;
    end

    // ------------------------------------------------------------------------
    // Expected results
    // ------------------------------------------------------------------------

    // Counter slot of a low word, H word or selector address, -1 if none
    function automatic int slotOf(CsrAddr addr, CsrAddr base, int first);
        int slot;
        slot = int'(addr) - int'(base);
        if (slot < first || slot >= NumCounters + 3 || slot == 1)
            return -1;
        return slot;
    endfunction

    function automatic logic implemented(CsrAddr addr);
        if (addr[9:8] != 2'b11)                   // Machine level only
            return 1'b0;
        if (slotOf(addr, CSR_MCYCLE, 0) >= 0 || slotOf(addr, CSR_MCYCLEH, 0) >= 0)
            return 1'b1;
        if (slotOf(addr, CSR_MHPMEVENT3 - 12'd3, 3) >= 0)
            return 1'b1;
        case (addr)
            CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID, CSR_MISA,
            CSR_MSTATUS, CSR_MTVEC, CSR_MIE, CSR_MIP, CSR_MSCRATCH, CSR_MEPC,
            CSR_MCAUSE, CSR_MCOUNTINHIBIT : return 1'b1;
            default                       : return 1'b0;
        endcase
    endfunction

    function automatic Data expectedRead(CsrAddr addr);
        int lo;
        int hi;
        int ev;
        lo = slotOf(addr, CSR_MCYCLE, 0);
        hi = slotOf(addr, CSR_MCYCLEH, 0);
        ev = slotOf(addr, CSR_MHPMEVENT3 - 12'd3, 3);
        if (!implemented(addr))
            return '0;
        if (lo >= 0)
            return refCount[lo][31:0];
        if (hi >= 0)
            return Data'(refCount[hi][32]);
        if (ev >= 0)
            return Data'(refEvent[ev]);
        case (addr)
            CSR_MISA          : return MISA;
            CSR_MVENDORID     : return MVENDORID;
            CSR_MARCHID       : return MARCHID;
            CSR_MIMPID        : return MIMPID;
            CSR_MHARTID       : return MHARTID;
            CSR_MSTATUS       : return refMstatus;
            CSR_MTVEC         : return refMtvec;
            CSR_MIE           : return refMie;
            CSR_MSCRATCH      : return refMscratch;
            CSR_MCOUNTINHIBIT : return refInhibitRead(NumCounters);
            default           : return '0;    // mip, mepc, mcause never written
        endcase
    endfunction

    function automatic void updateModel(CsrOp accOp, CsrAddr addr, Data value, Data oldValue,
                                        logic bad, logic instRet, logic [6:1] pulses);
        Data newValue;
        int  lo;
        int  ev;
        newValue = refWriteValue(accOp, oldValue, value) & refMask(addr);
        lo = slotOf(addr, CSR_MCYCLE, 0);
        ev = slotOf(addr, CSR_MHPMEVENT3 - 12'd3, 3);
        refTick(instRet, pulses);                 // Counting uses the old state
        if (accOp == CsrOp_NOP || bad)
            return;
        case (addr)
            CSR_MSTATUS       : refMstatus  = newValue;
            CSR_MTVEC         : refMtvec    = newValue;
            CSR_MIE           : refMie      = newValue;
            CSR_MSCRATCH      : refMscratch = newValue;
            CSR_MCOUNTINHIBIT : refInhibit  = newValue[MaxHpmCounters+2:0];
            default           : ;
        endcase
        if (lo >= 0)
            refCount[lo] = {1'b0, newValue};      // Load wins over the count
        if (ev >= 0)
            refEvent[ev] = HpmEvent'(newValue[3:0]);
    endfunction

    // ------------------------------------------------------------------------
    // Compare tasks and stimulus
    // ------------------------------------------------------------------------

    task automatic checkData(input string what, input Data actual, input Data expected);
        if (actual !== expected) begin
            dataErrors++;
            $display("Fail at %0t: %s read %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic checkIllegal(input string what, input logic actual, input logic expected);
        if (actual !== expected) begin
            illegalErrors++;
            $display("Fail at %0t: %s illegal flag %b, expected %b",
                     $time, what, actual, expected);
        end
    endtask

    // One clock cycle with an operation and event pulses
    task automatic access(input CsrOp accOp, input CsrAddr addr, input Data value,
                          input logic instRet, input logic [6:1] pulses);
        Data  expData;
        logic expIllegal;
        @(negedge clock);
        op        = accOp;
        csr       = addr;
        dataIn    = value;
        evInstRet = instRet;
        {evMemWrite, evMemRead, evDCacheMis, evDCacheHit, evICacheMis, evICacheHit} = pulses;
        expData    = expectedRead(addr);
        expIllegal = (accOp != CsrOp_NOP) && (!implemented(addr) || addr[11:10] == 2'b11);
        #(Period / 4);
        lastRead = dataOut;
        checkData($sformatf("CSR %h", addr), dataOut, expData);
        checkIllegal($sformatf("CSR %h op %s", addr, accOp.name()), illegal, expIllegal);
        updateModel(accOp, addr, value, expData, expIllegal, instRet, pulses);
    endtask

    task automatic readCsr(input CsrAddr addr);
        access(CsrOp_NOP, addr, '0, 1'b0, '0);
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------

    initial begin
        CsrAddr     regList [4];
        CsrAddr     target;
        CsrOp       kind;
        logic [31:0] randomBits;
        Data        first;
        int         pulseCount;
        int         missCount;
        int         writeCount;

        regList = '{CSR_MSCRATCH, CSR_MTVEC, CSR_MIE, CSR_MSTATUS};
        reset       = 1'b1;
        op          = CsrOp_NOP;
        csr         = CSR_MSTATUS;
        dataIn      = '0;
        evInstRet   = 1'b0;
        evICacheHit = 1'b0;
        evICacheMis = 1'b0;
        evDCacheHit = 1'b0;
        evDCacheMis = 1'b0;
        evMemRead   = 1'b0;
        evMemWrite  = 1'b0;
        dataErrors    = 0;
        illegalErrors = 0;
        refReset();
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        // Reset state
        readCsr(CSR_MSTATUS);
        readCsr(CSR_MTVEC);
        readCsr(CSR_MSCRATCH);
        readCsr(CSR_MISA);
        readCsr(CSR_MCOUNTINHIBIT);
        checkData("mcountinhibit after reset", lastRead, 32'h0000_001D);
        for (int i = 0; i < NumCounters + 3; i++) begin
            if (i != 1) begin
                readCsr(CSR_MCYCLE + CsrAddr'(i));
                readCsr(CSR_MCYCLEH + CsrAddr'(i));
            end
        end
        for (int i = 0; i < NumCounters; i++)
            readCsr(CSR_MHPMEVENT3 + CsrAddr'(i));

        // Random modify sequences
        for (int n = 0; n < RandomOps; n++) begin
            target = regList[$unsigned($random(seed)) % 4];
            kind   = CsrOp'(1 + $unsigned($random(seed)) % 3);
            access(kind, target, $random(seed), 1'b0, '0);
            readCsr(target);
        end

        // Illegal accesses
        access(CsrOp_WRITE, 12'h3A0, $random(seed), 1'b0, '0);  // Unimplemented
        access(CsrOp_WRITE, CSR_MHPMCOUNTER3 + 12'd2, $random(seed), 1'b0, '0);
        access(CsrOp_NOP, CSR_MHPMCOUNTER3H + 12'd2, '0, 1'b0, '0);
        access(CsrOp_CLEAR, CSR_MHPMEVENT3 + 12'd2, 32'hF, 1'b0, '0);
        access(CsrOp_SET, 12'h040, $random(seed), 1'b0, '0);     // User level
        access(CsrOp_WRITE, CSR_MVENDORID, 32'hDEAD_BEEF, 1'b0, '0);
        readCsr(CSR_MVENDORID);
        readCsr(CSR_MSCRATCH);
        readCsr(CSR_MHPMCOUNTER3);

        // mcycle and minstret
        access(CsrOp_CLEAR, CSR_MCOUNTINHIBIT, 32'h5, 1'b0, '0);
        pulseCount = 0;
        for (int n = 0; n < CountCycles; n++) begin
            randomBits = $random(seed);
            pulseCount += randomBits[0];
            access(CsrOp_NOP, CSR_MINSTRET, '0, randomBits[0], '0);
        end
        readCsr(CSR_MINSTRET);
        checkData("minstret pulse count", lastRead, Data'(pulseCount));
        readCsr(CSR_MCYCLE);
        first = lastRead;
        repeat (Gap - 1) readCsr(CSR_MSTATUS);
        readCsr(CSR_MCYCLE);
        checkData("mcycle distance", lastRead, first + Data'(Gap));

        // Programmable counters, counter 4 held first
        access(CsrOp_WRITE, CSR_MHPMEVENT3, Data'(HpmEvent_DCacheMiss), 1'b0, '0);
        access(CsrOp_WRITE, CSR_MHPMEVENT3 + 12'd1, Data'(HpmEvent_MemWrite), 1'b0, '0);
        access(CsrOp_CLEAR, CSR_MCOUNTINHIBIT, 32'h8, 1'b0, '0);
        missCount  = 0;
        writeCount = 0;
        for (int phase = 0; phase < 2; phase++) begin
            for (int n = 0; n < EventCycles; n++) begin
                randomBits = $random(seed);
                missCount += randomBits[3];
                if (phase == 1)
                    writeCount += randomBits[5];
                access(CsrOp_NOP, CSR_MHPMCOUNTER3 + CsrAddr'(n % 2), '0,
                       randomBits[6], randomBits[5:0]);
            end
            readCsr(CSR_MHPMCOUNTER3 + 12'd1);
            checkData("mhpmcounter4", lastRead, Data'(writeCount));
            if (phase == 0)
                access(CsrOp_CLEAR, CSR_MCOUNTINHIBIT, 32'h10, 1'b0, '0);
        end
        readCsr(CSR_MHPMCOUNTER3);
        checkData("mhpmcounter3", lastRead, Data'(missCount));

        // Carry into the H word
        access(CsrOp_WRITE, CSR_MHPMCOUNTER3, 32'hFFFF_FFFF, 1'b0, '0);
        access(CsrOp_NOP, CSR_MSTATUS, '0, 1'b0, 6'b00_1000);   // One DCache miss
        readCsr(CSR_MHPMCOUNTER3);
        checkData("mhpmcounter3 after wrap", lastRead, 32'h0);
        readCsr(CSR_MHPMCOUNTER3H);
        checkData("mhpmcounter3h after wrap", lastRead, 32'h1);

        $display("Errors: %0d data, %0d illegal flag", dataErrors, illegalErrors);
        if (dataErrors + illegalErrors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    // Watchdog
    initial begin
        #((TestCycles + Margin) * Period);
        $display("Timeout after %0d cycles, the test sequence did not finish",
                 TestCycles + Margin);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+include
src/CsrPkg.sv
src/CsrRegisters.sv
src/HpmCounterBank.sv
src/CsrUnit.sv
testbench/CsrUnitTb.sv

/* run.sh */
#!/bin/sh
# Build and run the CSR unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    -f project.f \
    --top-module CsrUnitTb \
    --Mdir "$BUILD" \
    -o CsrUnitTb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD/CsrUnitTb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0
